/* filelist.f */
hdl/aes_state_pkg.sv
hdl/aes_round_pkg.sv
hdl/byte_substitution_box.sv
hdl/sub_bytes_layer.sv
hdl/mix_add_stage.sv
hdl/aes_round_unit.sv
verif/aes_round_assertions.sv
verif/aes_round_tb.sv

/* hdl/aes_round_pkg.sv */
// Forward cipher arithmetic only; no inverse MixColumns is provided.
package aes_round_pkg;

    import aes_state_pkg::*;

    // Register stages present whatever the S-box setting.
    localparam int AES_STAGE_LAT = 1;

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1.
    function automatic aes_byte_t gf_double(aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One MixColumns column; 3*a is built as 2*a ^ a.
    function automatic aes_word_t mix_column(aes_word_t col);
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {gf_double(a0) ^ gf_double(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ gf_double(a1) ^ gf_double(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ gf_double(a2) ^ gf_double(a3) ^ a3,
                gf_double(a0) ^ a0 ^ a1 ^ a2 ^ gf_double(a3)};
    endfunction

endpackage

/* hdl/aes_round_unit.sv */
// Forward AES-128 round, no back-pressure; latency is 1 + P_SBOX_OUTPUT_REG cycles.
module aes_round_unit
    import aes_state_pkg::*;
#(
    parameter int P_SBOX_OUTPUT_REG = 1
)
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,
    input  aes_state_t i_state,
    input  aes_state_t i_round_key,
    input  logic       i_final_round,
    output logic       o_valid,
    output aes_state_t o_state
);

    logic       sub_valid;
    aes_state_t sub_state;      // Already shifted.
    aes_state_t sub_round_key;
    logic       sub_final;

    sub_bytes_layer
    #(
        .P_SBOX_OUTPUT_REG (P_SBOX_OUTPUT_REG)
    )
    u_sub_bytes_layer
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_state       (i_state),
        .i_round_key   (i_round_key),
        .i_final_round (i_final_round),
        .o_valid       (sub_valid),
        .o_state       (sub_state),
        .o_round_key   (sub_round_key),
        .o_final_round (sub_final)
    );

    mix_add_stage
    u_mix_add_stage
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (sub_valid),
        .i_state       (sub_state),
        .i_round_key   (sub_round_key),
        .i_final_round (sub_final),
        .o_valid       (o_valid),
        .o_state       (o_state)
    );

endmodule

/* hdl/aes_state_pkg.sv */
// Column-major FIPS-197 state with byte 0 in bits 127:120; helpers take constant indexes in range.
package aes_state_pkg;

    localparam int AES_NB_ROWS  = 4;
    localparam int AES_NB_COLS  = 4;
    localparam int AES_NB_BYTES = AES_NB_ROWS * AES_NB_COLS;

    typedef logic [7:0]   aes_byte_t;   // One state byte.
    typedef logic [31:0]  aes_word_t;   // One column, row 0 on top.
    typedef logic [127:0] aes_state_t;  // Sixteen bytes, column after column.

    // Byte n of a state, counted from the top.
    function automatic aes_byte_t state_byte(aes_state_t state, int n);
        return state[8*(AES_NB_BYTES-1-n) +: 8];
    endfunction

    // Column c of a state.
    function automatic aes_word_t state_word(aes_state_t state, int c);
        return state[32*(AES_NB_COLS-1-c) +: 32];
    endfunction

    // Position of (row, col) in the byte order.
    function automatic int byte_index(int row, int col);
        return AES_NB_ROWS*col + row;
    endfunction

endpackage

/* hdl/byte_substitution_box.sv */
// Forward S-box for one byte; NB_BYTE must stay 8, and the register holds while i_valid is low.
module byte_substitution_box
    import aes_state_pkg::*;
#(
    parameter int NB_BYTE           = 8,
    parameter int CREATE_OUTPUT_REG = 0
)
(
    input  logic      i_clock,
    input  logic      i_valid,
    input  aes_byte_t i_byte,
    output aes_byte_t o_byte
);

    // Entry 0 sits in the top byte, one table row per line.
    localparam logic [0:2**NB_BYTE-1][NB_BYTE-1:0] SBOX_TABLE = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,   // 0x.
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,   // 1x.
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,   // 8x.
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16    // fx.
    };

    aes_byte_t sbox_value;

    assign sbox_value = SBOX_TABLE[i_byte];

    generate
        if (CREATE_OUTPUT_REG == 1)
        begin : g_out_reg
            // Payload only, no reset.
            always_ff @(posedge i_clock)
            begin
                if (i_valid)
                begin
                    o_byte <= sbox_value;
                end
            end
        end
        else
        begin : g_out_comb
            always_comb
            begin
                o_byte = sbox_value;
            end
        end
    endgenerate

endmodule

/* hdl/mix_add_stage.sv */
// MixColumns and AddRoundKey with one output register; o_state holds its last value between strobes.
module mix_add_stage
    import aes_state_pkg::*;
    import aes_round_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,
    input  aes_state_t i_state,
    input  aes_state_pkg::aes_state_t i_round_key,
    input  logic       i_final_round,
    output logic       o_valid,
    output aes_state_t o_state
);

    aes_state_t mixed_state;
    aes_state_t round_state;

    // Final round skips the column mix.
    always_comb
    begin
        for (int c = 0; c < AES_NB_COLS; c++)
        begin
            if (i_final_round)
                mixed_state[32*(AES_NB_COLS-1-c) +: 32] = state_word(i_state, c);
            else
                mixed_state[32*(AES_NB_COLS-1-c) +: 32] = mix_column(state_word(i_state, c));
        end
    end

    assign round_state = mixed_state ^ i_round_key;   // AddRoundKey.

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_state <= round_state;
        end
    end

endmodule

/* hdl/sub_bytes_layer.sv */
// SubBytes plus ShiftRows; with P_SBOX_OUTPUT_REG = 0 the whole layer is combinational.
module sub_bytes_layer
    import aes_state_pkg::*;
#(
    parameter int P_SBOX_OUTPUT_REG = 1
)
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_valid,
    input  aes_state_t i_state,
    input  aes_state_t i_round_key,
    input  logic       i_final_round,
    output logic       o_valid,
    output aes_state_t o_state,
    output aes_state_t o_round_key,
    output logic       o_final_round
);

    aes_byte_t sbox_byte [AES_NB_BYTES];

    for (genvar n = 0; n < AES_NB_BYTES; n++)
    begin : g_sbox
        byte_substitution_box
        #(
            .NB_BYTE           (8),
            .CREATE_OUTPUT_REG (P_SBOX_OUTPUT_REG)
        )
        u_sbox
        (
            .i_clock (i_clock),
            .i_valid (i_valid),
            .i_byte  (state_byte(i_state, n)),
            .o_byte  (sbox_byte[n])
        );
    end

    // Row r rotates left by r columns.
    for (genvar r = 0; r < AES_NB_ROWS; r++)
    begin : g_row
        for (genvar c = 0; c < AES_NB_COLS; c++)
        begin : g_col
            assign o_state[8*(AES_NB_BYTES-1-byte_index(r, c)) +: 8] =
                sbox_byte[byte_index(r, (c + r) % AES_NB_COLS)];
        end
    end

    // Side signals follow the S-box latency.
    if (P_SBOX_OUTPUT_REG == 1)
    begin : g_delay
        always_ff @(posedge i_clock)
        begin
            if (i_reset)
                o_valid <= 1'b0;
            else
                o_valid <= i_valid;
        end

        always_ff @(posedge i_clock)
        begin
            if (i_valid)
            begin
                o_round_key   <= i_round_key;
                o_final_round <= i_final_round;
            end
        end
    end
    else
    begin : g_no_delay
        always_comb
        begin
            o_valid       = i_valid;
            o_round_key   = i_round_key;
            o_final_round = i_final_round;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the AES round testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module aes_round_tb \
    -f filelist.f \
    -o aes_round_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/aes_round_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" <<< "$output"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

/* verif/aes_round_assertions.sv */
// Bound into aes_round_unit; its P_SBOX_OUTPUT_REG must follow the unit it watches.
module aes_round_assertions
    import aes_state_pkg::*;
    import aes_round_pkg::*;
#(
    parameter int P_SBOX_OUTPUT_REG = 1
)
(
    input logic       i_clock,
    input logic       i_reset,
    input logic       i_valid,
    input logic       i_out_valid,
    input aes_state_t i_out_state
);

    // Strobe cleared by reset.
    reset_clears_valid: assert property (@(posedge i_clock) i_reset |=> !i_out_valid)
        else $error("o_valid high in the cycle after reset");

    valid_latency: assert property (@(posedge i_clock) disable iff (i_reset)
        i_valid |-> ##(AES_STAGE_LAT + P_SBOX_OUTPUT_REG) i_out_valid)
        else $error("o_valid missing at the fixed latency after i_valid");

    state_known: assert property (@(posedge i_clock) disable iff (i_reset)
        i_out_valid |-> !$isunknown(i_out_state))
        else $error("o_state unknown while o_valid is high");

endmodule

bind aes_round_unit aes_round_assertions
#(
    .P_SBOX_OUTPUT_REG (P_SBOX_OUTPUT_REG)
)
u_round_assertions
(
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_out_valid (o_valid),
    .i_out_state (o_state)
);

/* verif/aes_round_tb.sv */
// Run from the project root to find the data file; assumes the default 2-cycle latency.
module aes_round_tb
    import aes_state_pkg::*;
();

    localparam int CLOCK_PERIOD  = 40;
    localparam int MAX_VECTORS   = 32;
    localparam int WORDS_PER_VEC = 4;    // Flag, state, key, expected.
    localparam int LATENCY       = 2;
    localparam int IDLE_CYCLES   = 8;

    logic       i_clock;
    logic       i_reset;
    logic       i_valid;
    aes_state_t i_state;
    aes_state_t i_round_key;
    logic       i_final_round;
    logic       o_valid;
    aes_state_t o_state;

    logic [127:0] vec_mem [WORDS_PER_VEC*MAX_VECTORS];
    int           num_vectors    = 0;
    int           sent_count     = 0;
    int           pulse_count    = 0;
    int           cycle_count    = 0;
    int           timeout_cycles = 0;
    aes_state_t   expect_q [$];
    int           due_q [$];

    aes_round_unit i_dut
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_state       (i_state),
        .i_round_key   (i_round_key),
        .i_final_round (i_final_round),
        .o_valid       (o_valid),
        .o_state       (o_state)
    );

    initial
    begin
        i_clock = 1'b0;
        forever
        begin
            #(CLOCK_PERIOD/2) i_clock = ~i_clock;
        end
    end

    always @(posedge i_clock)
    begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_state(input string name, input aes_state_t expected,
                               input aes_state_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Sentinel above any legal flag word.
    task automatic fill_memory();
        for (int a = 0; a < WORDS_PER_VEC*MAX_VECTORS; a++)
        begin
            vec_mem[a] = {96'hffff_ffff_ffff_ffff_ffff_ffff, 32'(a)};
        end
    endtask

    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VECTORS && vec_mem[WORDS_PER_VEC*n] <= 128'd1)
        begin
            n++;
        end
        return n;
    endfunction

    task automatic send_vector(input int idx);
        int base;
        base = WORDS_PER_VEC * idx;
        @(negedge i_clock);
        i_valid       = 1'b1;
        i_final_round = vec_mem[base][0];
        i_state       = vec_mem[base + 1];
        i_round_key   = vec_mem[base + 2];
        expect_q.push_back(vec_mem[base + 3]);
        due_q.push_back(cycle_count + LATENCY);   // Edge at which the monitor sees it.
        sent_count++;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge i_clock);
            i_valid = 1'b0;
        end
    endtask

    task automatic wait_for_drain();
        while (due_q.size() > 0)
        begin
            @(posedge i_clock);
        end
    endtask

    // Values seen here were set at the previous edge.
    task automatic watch_output();
        logic due_now;
        due_now = (due_q.size() > 0) && (due_q[0] == cycle_count);
        if (o_valid === 1'b1)
        begin
            pulse_count++;   // Strobes as the DUT drives them.
        end
        check_valid("o_valid", due_now, o_valid);
        if (due_now)
        begin
            check_state("o_state", expect_q.pop_front(), o_state);
            void'(due_q.pop_front());
        end
    endtask

    always @(posedge i_clock)
    begin
        if (i_reset === 1'b0)
        begin
            watch_output();
        end
    end

    initial
    begin
        #1;
        repeat (timeout_cycles) @(posedge i_clock);
        abort_run($sformatf("Timeout after %0d cycles with %0d results still pending.",
                            timeout_cycles, due_q.size()));
    end

    initial
    begin
        int gap;
        i_reset       = 1'b1;
        i_valid       = 1'b0;
        i_state       = '0;
        i_round_key   = '0;
        i_final_round = 1'b0;
        void'($urandom(32'h72e6_ad20));
        fill_memory();
        $readmemh("verif/aes_round_testdata.hex", vec_mem);
        num_vectors = count_vectors();
        if (num_vectors == 0)
        begin
            abort_run("No test vectors were read from the data file.");
        end
        timeout_cycles = 2 * num_vectors * 5 + 20;

        repeat (2) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        drive_idle(IDLE_CYCLES);   // No strobe may appear here.

        // Back to back.
        for (int k = 0; k < num_vectors; k++)
        begin
            send_vector(k);
        end
        drive_idle(LATENCY + 1);

        for (int k = 0; k < num_vectors; k++)
        begin
            gap = $urandom_range(3, 0);
            drive_idle(gap);
            send_vector(k);
        end
        drive_idle(1);
        wait_for_drain();
        drive_idle(4);             // Catches late stray strobes.

        if (pulse_count != sent_count)
        begin
            abort_run($sformatf("Saw %0d output strobes for %0d transfers sent.",
                                pulse_count, sent_count));
        end
        else
        begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* verif/aes_round_testdata.hex */
// Columns: final-round flag, input state, round key, expected state after the round.
// FIPS-197 Appendix B rounds 1 to 10, then Appendix C.1 rounds 1 to 10.
0 193de3bea0f4e22b9ac68d2ae9f84808 a0fafe1788542cb123a339392a6c7605 a49c7ff2689f352b6b5bea43026a5049
0 a49c7ff2689f352b6b5bea43026a5049 f2c295f27a96b9435935807a7359f67f aa8f5f0361dde3ef82d24ad26832469a
0 aa8f5f0361dde3ef82d24ad26832469a 3d80477d4716fe3e1e237e446d7a883b 486c4eee671d9d0d4de3b138d65f58e7
0 486c4eee671d9d0d4de3b138d65f58e7 ef44a541a8525b7fb671253bdb0bad00 e0927fe8c86363c0d9b1355085b8be01
0 e0927fe8c86363c0d9b1355085b8be01 d4d1c6f87c839d87caf2b8bc11f915bc f1006f55c1924cef7cc88b325db5d50c
0 f1006f55c1924cef7cc88b325db5d50c 6d88a37a110b3efddbf98641ca0093fd 260e2e173d41b77de86472a9fdd28b25
0 260e2e173d41b77de86472a9fdd28b25 4e54f70e5f5fc9f384a64fb24ea6dc4f 5a4142b11949dc1fa3e019657a8c040c
0 5a4142b11949dc1fa3e019657a8c040c ead27321b58dbad2312bf5607f8d292f ea835cf00445332d655d98ad8596b0c5
0 ea835cf00445332d655d98ad8596b0c5 ac7766f319fadc2128d12941575c006e eb40f21e592e38848ba113e71bc342d2
1 eb40f21e592e38848ba113e71bc342d2 d014f9a8c9ee2589e13f0cc8b6630ca6 3925841d02dc09fbdc118597196a0b32
0 00102030405060708090a0b0c0d0e0f0 d6aa74fdd2af72fadaa678f1d6ab76fe 89d810e8855ace682d1843d8cb128fe4
0 89d810e8855ace682d1843d8cb128fe4 b692cf0b643dbdf1be9bc5006830b3fe 4915598f55e5d7a0daca94fa1f0a63f7
0 4915598f55e5d7a0daca94fa1f0a63f7 b6ff744ed2c2c9bf6c590cbf0469bf41 fa636a2825b339c940668a3157244d17
0 fa636a2825b339c940668a3157244d17 47f7f7bc95353e03f96c32bcfd058dfd 247240236966b3fa6ed2753288425b6c
0 247240236966b3fa6ed2753288425b6c 3caaa3e8a99f9deb50f3af57adf622aa c81677bc9b7ac93b25027992b0261996
0 c81677bc9b7ac93b25027992b0261996 5e390f7df7a69296a7553dc10aa31f6b c62fe109f75eedc3cc79395d84f9cf5d
0 c62fe109f75eedc3cc79395d84f9cf5d 14f9701ae35fe28c440adf4d4ea9c026 d1876c0f79c4300ab45594add66ff41f
0 d1876c0f79c4300ab45594add66ff41f 47438735a41c65b9e016baf4aebf7ad2 fde3bad205e5d0d73547964ef1fe37f1
0 fde3bad205e5d0d73547964ef1fe37f1 549932d1f08557681093ed9cbe2c974e bd6e7c3df2b5779e0b61216e8b10b689
1 bd6e7c3df2b5779e0b61216e8b10b689 13111d7fe3944a17f307a78b4d2b30c5 69c4e0d86a7b0430d8cdb78070b4c55a
